// File: logic/tlk2711_link_pkg.sv
`default_nettype none

package tlk2711_link_pkg;

    ////////////////////////////////////////
    // 8b/10b characters
    ////////////////////////////////////////

    // comma and its data partner
    localparam logic [7:0] K28_5 = 8'hBC;
    localparam logic [7:0] D5_6  = 8'hC5;
    // start of frame
    localparam logic [7:0] K28_2 = 8'h5C;
    localparam logic [7:0] K27_7 = 8'hFB;
    // end of frame
    localparam logic [7:0] K29_7 = 8'hFD;
    localparam logic [7:0] K30_7 = 8'hFE;

    // link word width, one txd word per clock
    localparam int LANE_W = 16;

    // coded words, upper byte goes on the msb lane
    localparam logic [LANE_W-1:0] COMMA_WORD = {D5_6, K28_5};
    localparam logic [LANE_W-1:0] SOF_WORD   = {K28_2, K27_7};
    localparam logic [LANE_W-1:0] EOF_WORD   = {K29_7, K30_7};

    // transmit mode, any code other than KCODE runs as normal framing
    typedef enum logic [2:0] {
        NORM  = 3'd0,
        KCODE = 3'd1
    } tx_mode_e;

endpackage

`default_nettype wire

// File: logic/tx_frame_pkg.sv
`default_nettype none

package tx_frame_pkg;

    ////////////////////////////////////////
    // frame format
    ////////////////////////////////////////

    // two fixed header words after the start code
    localparam logic [15:0] HEAD_0 = 16'hEB90;
    localparam logic [15:0] HEAD_1 = 16'hE116;

    // file sign word is {TX_IND, FILE_END or zero}
    localparam logic [7:0] TX_IND   = 8'h81;
    localparam logic [7:0] FILE_END = 8'h01;

    // frame number counter
    localparam int FRAME_CNT_W = 24;

    ////////////////////////////////////////
    // sequencer states
    ////////////////////////////////////////

    typedef enum logic [3:0] {
        IDLE      = 4'd0,
        BEGIN     = 4'd1,
        SYNC      = 4'd2,
        SOF       = 4'd3,
        HEAD      = 4'd4,
        FILE_SIGN = 4'd5,
        FRAME_NUM = 4'd6,
        LENGTH    = 4'd7,
        DATA      = 4'd8,
        CHECKSUM  = 4'd9,
        EOF       = 4'd10,
        GAP       = 4'd11,
        INTERRUPT = 4'd12
    } frame_state_e;

endpackage

`default_nettype wire

// File: logic/tx_dma_fifo.sv
`default_nettype none

module tx_dma_fifo
    import tlk2711_link_pkg::*;
#(
    parameter int DATA_WIDTH = 64,
    parameter int FIFO_DEPTH = 512
) (
    input  logic                  clk,
    input  logic                  i_soft_reset,
    input  logic                  i_wr_en,
    input  logic [DATA_WIDTH-1:0] i_wr_data,
    input  logic                  i_rd_en,
    output logic [LANE_W-1:0]     o_rd_word,
    output logic [LANE_W:0]       o_level,
    output logic                  o_full,
    output logic                  o_empty
);

    localparam int LANES  = DATA_WIDTH / LANE_W;
    localparam int PTR_W  = $clog2(FIFO_DEPTH);
    localparam int LIDX_W = $clog2(LANES);
    localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
    localparam int LVL_W  = LANE_W + 1;

    logic [DATA_WIDTH-1:0]         mem [FIFO_DEPTH];
    logic [LANES-1:0][LANE_W-1:0]  head_entry;
    logic [PTR_W-1:0]              wr_ptr;
    logic [PTR_W-1:0]              rd_ptr;
    logic [CNT_W-1:0]              entries;
    logic [LIDX_W-1:0]             lane;
    logic [LVL_W-1:0]              level;
    logic                          pop_entry;

    // last lane of the head entry frees its slot
    assign pop_entry = i_rd_en && (lane == LIDX_W'(LANES - 1));

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            entries <= '0;
            lane    <= '0;
            level   <= '0;
        end else begin
            if (i_wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_entry) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (i_rd_en) begin
                lane <= pop_entry ? '0 : lane + 1'b1;
            end
            entries <= entries + CNT_W'(i_wr_en) - CNT_W'(pop_entry);
            // level in 16-bit words, a write adds a whole entry
            level <= level + (i_wr_en ? LVL_W'(LANES) : '0) - LVL_W'(i_rd_en);
        end
    end

    // fall-through head, lowest lane first
    assign head_entry = mem[rd_ptr];
    assign o_rd_word  = head_entry[lane];

    assign o_level = level;
    assign o_full  = (entries == CNT_W'(FIFO_DEPTH));
    assign o_empty = (entries == '0);

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // sequencer must only read a frame that is already buffered
    a_no_read_empty: assert property (
        @(posedge clk) disable iff (i_soft_reset) i_rd_en |-> !o_empty
    );

    // dma side is held off by ready
    a_no_write_full: assert property (
        @(posedge clk) disable iff (i_soft_reset) i_wr_en |-> !o_full
    );

endmodule

`default_nettype wire

// File: logic/tx_frame_ctrl.sv
`default_nettype none

module tx_frame_ctrl
    import tlk2711_link_pkg::*;
    import tx_frame_pkg::*;
#(
    parameter int SYNC_CYCLES = 6,
    parameter int GAP_CYCLES  = 257
) (
    input  logic                   clk,
    input  logic                   i_soft_reset,
    input  logic                   i_tx_start,
    input  tx_mode_e               i_tx_mode,
    input  logic [15:0]            i_tx_packet_body,
    input  logic [15:0]            i_tx_packet_tail,
    input  logic [FRAME_CNT_W-1:0] i_tx_body_num,
    input  logic [15:0]            i_tx_intr_width,
    input  logic [LANE_W:0]        i_fifo_level,
    output frame_state_e           o_state,
    output tx_mode_e               o_mode,
    output logic                   o_fifo_rd,
    output logic                   o_dma_enable,
    output logic [FRAME_CNT_W-1:0] o_frame_num,
    output logic [15:0]            o_valid_len,
    output logic                   o_last_frame,
    output logic                   o_tx_interrupt
);

    frame_state_e           state;
    frame_state_e           next_state;
    tx_mode_e               mode;
    logic                   cfg_flag;
    logic                   dma_en;
    logic                   tail_sent;
    logic [FRAME_CNT_W-1:0] frame_cnt;
    logic [15:0]            step_cnt;
    logic [15:0]            step_limit;
    logic                   step_done;
    logic                   frame_ready;
    logic                   intr_done;

    ////////////////////////////////////////
    // configuration
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            mode     <= NORM;
            cfg_flag <= 1'b0;
            dma_en   <= 1'b0;
        end else if (i_tx_start) begin
            mode     <= i_tx_mode;
            cfg_flag <= 1'b1;
            dma_en   <= (i_tx_mode != KCODE);
        end else if (intr_done) begin
            cfg_flag <= 1'b0;
        end
    end

    // the tail length goes with the last frame number
    assign o_last_frame = (frame_cnt == i_tx_body_num);
    assign o_valid_len  = o_last_frame ? i_tx_packet_tail : i_tx_packet_body;
    assign frame_ready  = (i_fifo_level >= {2'b00, o_valid_len[15:1]});

    ////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////

    // cycles spent in each state
    always_comb begin
        case (state)
            SYNC:      step_limit = 16'(SYNC_CYCLES);
            HEAD:      step_limit = 16'd2;
            DATA:      step_limit = {1'b0, o_valid_len[15:1]};
            GAP:       step_limit = 16'(GAP_CYCLES);
            INTERRUPT: step_limit = i_tx_intr_width;
            default:   step_limit = 16'd1;
        endcase
    end

    assign step_done = (step_cnt == step_limit - 16'd1);
    assign intr_done = (state == INTERRUPT) && step_done;

    always_comb begin
        next_state = state;
        case (state)
            IDLE:      if (cfg_flag && frame_ready) next_state = BEGIN;
            BEGIN:     next_state = SYNC;
            SYNC:      if (step_done) next_state = SOF;
            SOF:       next_state = HEAD;
            HEAD:      if (step_done) next_state = FILE_SIGN;
            FILE_SIGN: next_state = FRAME_NUM;
            FRAME_NUM: next_state = LENGTH;
            LENGTH:    next_state = DATA;
            DATA:      if (step_done) next_state = CHECKSUM;
            CHECKSUM:  next_state = EOF;
            EOF:       next_state = GAP;
            GAP: begin
                // keep sending commas until the next frame is buffered
                if (step_done && tail_sent) begin
                    next_state = INTERRUPT;
                end else if (step_done && frame_ready) begin
                    next_state = SOF;
                end
            end
            INTERRUPT: if (step_done) next_state = IDLE;
            default:   next_state = IDLE;
        endcase
        // kcode mode never frames
        if (mode == KCODE) begin
            next_state = IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // shared step counter restarts on every state change and saturates
    always_ff @(posedge clk) begin
        if (i_soft_reset || (state != next_state)) begin
            step_cnt <= '0;
        end else if (!step_done) begin
            step_cnt <= step_cnt + 16'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_soft_reset || intr_done) begin
            frame_cnt <= '0;
            tail_sent <= 1'b0;
        end else if (state == EOF) begin
            frame_cnt <= frame_cnt + 1'b1;
            tail_sent <= o_last_frame;
        end
    end

    assign o_state        = state;
    assign o_mode         = mode;
    assign o_fifo_rd      = (state == DATA);
    assign o_dma_enable   = dma_en;
    assign o_frame_num    = frame_cnt;
    assign o_tx_interrupt = (state == INTERRUPT);

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // kcode is only latched while the sequencer sits in idle
    a_kcode_idle: assert property (
        @(posedge clk) disable iff (i_soft_reset) (mode == KCODE) |-> (state == IDLE)
    );

    // every frame up to the tail went out before the interrupt
    a_intr_after_tail: assert property (
        @(posedge clk) disable iff (i_soft_reset)
        o_tx_interrupt |-> tail_sent && (frame_cnt == i_tx_body_num + 1'b1)
    );

endmodule

`default_nettype wire

// File: logic/tx_word_builder.sv
`default_nettype none

module tx_word_builder
    import tlk2711_link_pkg::*;
    import tx_frame_pkg::*;
(
    input  logic                   clk,
    input  logic                   i_soft_reset,
    input  frame_state_e           i_state,
    input  tx_mode_e               i_mode,
    input  logic [LANE_W-1:0]      i_fifo_word,
    input  logic [FRAME_CNT_W-1:0] i_frame_num,
    input  logic [15:0]            i_valid_len,
    input  logic                   i_last_frame,
    output logic [LANE_W-1:0]      o_txd,
    output logic                   o_tkmsb,
    output logic                   o_tklsb,
    output logic                   o_enable,
    output logic                   o_lckrefn
);

    logic [LANE_W-1:0] word;
    logic [1:0]        kflags;
    logic [LANE_W-1:0] checksum;
    logic              head_second;

    // word select, kflags is {msb, lsb}
    always_comb begin
        word   = COMMA_WORD;
        kflags = 2'b01;
        if (i_mode == KCODE) begin
            word   = SOF_WORD;
            kflags = 2'b11;
        end else begin
            case (i_state)
                SOF: begin
                    word   = SOF_WORD;
                    kflags = 2'b11;
                end
                HEAD: begin
                    word   = head_second ? HEAD_1 : HEAD_0;
                    kflags = 2'b00;
                end
                FILE_SIGN: begin
                    word   = {TX_IND, i_last_frame ? FILE_END : 8'h00};
                    kflags = 2'b00;
                end
                FRAME_NUM: begin
                    word   = i_frame_num[LANE_W-1:0];
                    kflags = 2'b00;
                end
                LENGTH: begin
                    word   = i_valid_len;
                    kflags = 2'b00;
                end
                DATA: begin
                    word   = i_fifo_word;
                    kflags = 2'b00;
                end
                CHECKSUM: begin
                    word   = checksum;
                    kflags = 2'b00;
                end
                EOF: begin
                    word   = EOF_WORD;
                    kflags = 2'b11;
                end
                default: ;
            endcase
        end
    end

    // running sum from file sign through the last data word
    always_ff @(posedge clk) begin
        if (i_state == SOF) begin
            checksum <= '0;
        end else if (i_state inside {FILE_SIGN, FRAME_NUM, LENGTH, DATA}) begin
            checksum <= checksum + word;
        end
    end

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            head_second <= 1'b0;
            o_txd       <= COMMA_WORD;
            o_tkmsb     <= 1'b0;
            o_tklsb     <= 1'b1;
            o_enable    <= 1'b0;
            o_lckrefn   <= 1'b0;
        end else begin
            head_second <= (i_state == HEAD) && !head_second;
            // output holds during the interrupt window
            if (i_state != INTERRUPT) begin
                o_txd              <= word;
                {o_tkmsb, o_tklsb} <= kflags;
            end
            o_enable  <= 1'b1;
            o_lckrefn <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/tlk2711_tx.sv
`default_nettype none

module tlk2711_tx
    import tlk2711_link_pkg::*;
    import tx_frame_pkg::*;
#(
    parameter int DATA_WIDTH  = 64,
    parameter int FIFO_DEPTH  = 512,
    parameter int SYNC_CYCLES = 6,
    parameter int GAP_CYCLES  = 257
) (
    input  logic                   clk,
    input  logic                   i_soft_reset,
    input  logic                   i_tx_start,
    input  logic [2:0]             i_tx_mode,
    input  logic                   i_loopback_ena,
    input  logic                   i_tx_pre,
    input  logic [15:0]            i_tx_packet_body,
    input  logic [15:0]            i_tx_packet_tail,
    input  logic [FRAME_CNT_W-1:0] i_tx_body_num,
    input  logic [15:0]            i_tx_intr_width,
    input  logic                   i_dma_rd_valid,
    input  logic [DATA_WIDTH-1:0]  i_dma_rd_data,
    output logic                   o_dma_rd_ready,
    output logic                   o_tx_interrupt,
    output logic [9:0]             o_tx_status,
    output logic [LANE_W-1:0]      o_2711_txd,
    output logic                   o_2711_tkmsb,
    output logic                   o_2711_tklsb,
    output logic                   o_2711_enable,
    output logic                   o_2711_lckrefn,
    output logic                   o_2711_loopen,
    output logic                   o_2711_pre
);

    frame_state_e           state;
    tx_mode_e               mode;
    logic                   fifo_wr;
    logic                   fifo_rd;
    logic                   fifo_full;
    logic                   fifo_empty;
    logic [LANE_W-1:0]      fifo_word;
    logic [LANE_W:0]        fifo_level;
    logic                   dma_enable;
    logic [FRAME_CNT_W-1:0] frame_num;
    logic [15:0]            valid_len;
    logic                   last_frame;

    ////////////////////////////////////////
    // dma side
    ////////////////////////////////////////

    assign o_dma_rd_ready = !fifo_full;
    assign fifo_wr        = i_dma_rd_valid && o_dma_rd_ready && dma_enable;

    tx_dma_fifo #(
        .DATA_WIDTH (DATA_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_wr_en      (fifo_wr),
        .i_wr_data    (i_dma_rd_data),
        .i_rd_en      (fifo_rd),
        .o_rd_word    (fifo_word),
        .o_level      (fifo_level),
        .o_full       (fifo_full),
        .o_empty      (fifo_empty)
    );

    tx_frame_ctrl #(
        .SYNC_CYCLES (SYNC_CYCLES),
        .GAP_CYCLES  (GAP_CYCLES)
    ) u_ctrl (
        .clk              (clk),
        .i_soft_reset     (i_soft_reset),
        .i_tx_start       (i_tx_start),
        .i_tx_mode        (tx_mode_e'(i_tx_mode)),
        .i_tx_packet_body (i_tx_packet_body),
        .i_tx_packet_tail (i_tx_packet_tail),
        .i_tx_body_num    (i_tx_body_num),
        .i_tx_intr_width  (i_tx_intr_width),
        .i_fifo_level     (fifo_level),
        .o_state          (state),
        .o_mode           (mode),
        .o_fifo_rd        (fifo_rd),
        .o_dma_enable     (dma_enable),
        .o_frame_num      (frame_num),
        .o_valid_len      (valid_len),
        .o_last_frame     (last_frame),
        .o_tx_interrupt   (o_tx_interrupt)
    );

    ////////////////////////////////////////
    // link side
    ////////////////////////////////////////

    tx_word_builder u_builder (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_state      (state),
        .i_mode       (mode),
        .i_fifo_word  (fifo_word),
        .i_frame_num  (frame_num),
        .i_valid_len  (valid_len),
        .i_last_frame (last_frame),
        .o_txd        (o_2711_txd),
        .o_tkmsb      (o_2711_tkmsb),
        .o_tklsb      (o_2711_tklsb),
        .o_enable     (o_2711_enable),
        .o_lckrefn    (o_2711_lckrefn)
    );

    assign o_2711_loopen = i_loopback_ena;
    assign o_2711_pre    = i_tx_pre;

    // mode field padded to 4 bits
    assign o_tx_status = {fifo_empty, fifo_full, state, 1'b0, mode};

endmodule

`default_nettype wire

// File: verification/tb_tlk2711_tx.sv
`default_nettype none

module tb_tlk2711_tx
    import tlk2711_link_pkg::*;
    import tx_frame_pkg::*;
();

    typedef logic [15:0] word_q_t[$];
    typedef logic [63:0] dma_q_t[$];

    localparam int FIFO_DEPTH = 4;
    localparam int SYNC_CYC   = 6;
    localparam int GAP_CYC    = 8;
    localparam int INTR_W     = 5;
    localparam int KCODE_CYC  = 16;
    // normal transfer
    localparam int A_BODY  = 8;
    localparam int A_TAIL  = 4;
    localparam int A_CNT   = 2;
    localparam int A_WORDS = 3;
    // back-pressure transfer offers more than the fifo holds
    localparam int B_BODY  = 32;
    localparam int B_TAIL  = 12;
    localparam int B_CNT   = 3;
    localparam int B_WORDS = 14;
    // start code, two heads, sign, number, length, checksum, end code
    localparam int FRAME_FIXED = 8;
    localparam int RUN_A = (A_CNT + 1) * (FRAME_FIXED + GAP_CYC)
        + (A_CNT * A_BODY + A_TAIL) / 2 + SYNC_CYC + 1 + INTR_W;
    localparam int RUN_B = (B_CNT + 1) * (FRAME_FIXED + GAP_CYC)
        + (B_CNT * B_BODY + B_TAIL) / 2 + SYNC_CYC + 1 + INTR_W;
    localparam int RUN_LIMIT = 2 * (RUN_A + RUN_B + KCODE_CYC) + 2000;

    logic        clk = 1'b0;
    logic        i_soft_reset;
    logic        i_tx_start;
    logic [2:0]  i_tx_mode;
    logic        i_loopback_ena;
    logic        i_tx_pre;
    logic [15:0] i_tx_packet_body;
    logic [15:0] i_tx_packet_tail;
    logic [23:0] i_tx_body_num;
    logic [15:0] i_tx_intr_width;
    logic        i_dma_rd_valid;
    logic [63:0] i_dma_rd_data;
    logic        o_dma_rd_ready;
    logic        o_tx_interrupt;
    logic [9:0]  o_tx_status;
    logic [15:0] o_2711_txd;
    logic        o_2711_tkmsb;
    logic        o_2711_tklsb;
    logic        o_2711_enable;
    logic        o_2711_lckrefn;
    logic        o_2711_loopen;
    logic        o_2711_pre;

    integer  seed = 1830;
    int      cycle_count = 0;
    logic    saw_ready_low = 1'b0;
    dma_q_t  dma_words;
    word_q_t lane_stream;

    tlk2711_tx #(
        .DATA_WIDTH  (64),
        .FIFO_DEPTH  (FIFO_DEPTH),
        .SYNC_CYCLES (SYNC_CYC),
        .GAP_CYCLES  (GAP_CYC)
    ) tlk2711_tx_inst (
        .clk              (clk),
        .i_soft_reset     (i_soft_reset),
        .i_tx_start       (i_tx_start),
        .i_tx_mode        (i_tx_mode),
        .i_loopback_ena   (i_loopback_ena),
        .i_tx_pre         (i_tx_pre),
        .i_tx_packet_body (i_tx_packet_body),
        .i_tx_packet_tail (i_tx_packet_tail),
        .i_tx_body_num    (i_tx_body_num),
        .i_tx_intr_width  (i_tx_intr_width),
        .i_dma_rd_valid   (i_dma_rd_valid),
        .i_dma_rd_data    (i_dma_rd_data),
        .o_dma_rd_ready   (o_dma_rd_ready),
        .o_tx_interrupt   (o_tx_interrupt),
        .o_tx_status      (o_tx_status),
        .o_2711_txd       (o_2711_txd),
        .o_2711_tkmsb     (o_2711_tkmsb),
        .o_2711_tklsb     (o_2711_tklsb),
        .o_2711_enable    (o_2711_enable),
        .o_2711_lckrefn   (o_2711_lckrefn),
        .o_2711_loopen    (o_2711_loopen),
        .o_2711_pre       (o_2711_pre)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////
    // failure handling and compares
    ////////////////////////////////////////

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input logic [15:0] actual, input logic [15:0] expected,
                              input string name);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch at time %0t: %s is %h, expected %h",
                                        $time, name, actual, expected));
        end
    endtask

    task automatic check_kflags(input logic [1:0] actual, input logic [1:0] expected,
                                input string name);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch at time %0t: %s is %b, expected %b",
                                        $time, name, actual, expected));
        end
    endtask

    task automatic check_level(input logic actual, input logic expected, input string name);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch at time %0t: %s is %b, expected %b",
                                        $time, name, actual, expected));
        end
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= RUN_LIMIT) begin
            stop_with_failure("Timeout: the link never finished its frames in time");
        end
    end

    ////////////////////////////////////////
    // reference frame model
    ////////////////////////////////////////

    function automatic word_q_t build_frame(input int frame_num, input int body_len,
                                            input int tail_len, input int body_cnt,
                                            input word_q_t lanes);
        word_q_t     frame;
        logic [15:0] sign;
        logic [15:0] len;
        logic [15:0] sum;
        int          base;
        int          i;
        len  = (frame_num == body_cnt) ? 16'(tail_len) : 16'(body_len);
        sign = {TX_IND, (frame_num == body_cnt) ? FILE_END : 8'h00};
        // all earlier frames were body frames
        base = frame_num * body_len / 2;
        frame.push_back(SOF_WORD);
        frame.push_back(HEAD_0);
        frame.push_back(HEAD_1);
        frame.push_back(sign);
        frame.push_back(16'(frame_num));
        frame.push_back(len);
        sum = sign + 16'(frame_num) + len;
        for (i = 0; i < int'(len) / 2; i++) begin
            frame.push_back(lanes[base + i]);
            sum = sum + lanes[base + i];
        end
        frame.push_back(sum);
        frame.push_back(EOF_WORD);
        return frame;
    endfunction

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    task automatic make_stream(input int count);
        logic [63:0] w;
        int          k;
        dma_words   = {};
        lane_stream = {};
        for (k = 0; k < count; k++) begin
            w = {$random(seed), $random(seed)};
            dma_words.push_back(w);
            // lowest lane goes out first
            lane_stream.push_back(w[15:0]);
            lane_stream.push_back(w[31:16]);
            lane_stream.push_back(w[47:32]);
            lane_stream.push_back(w[63:48]);
        end
    endtask

    task automatic apply_reset();
        i_soft_reset = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_level(o_tx_interrupt, 1'b0, "o_tx_interrupt");
            check_level(o_2711_enable, 1'b0, "o_2711_enable");
            check_level(o_2711_lckrefn, 1'b0, "o_2711_lckrefn");
            expect_idle_word();
        end
        i_soft_reset = 1'b0;
        @(negedge clk);
        check_level(o_2711_enable, 1'b1, "o_2711_enable");
        check_level(o_2711_lckrefn, 1'b1, "o_2711_lckrefn");
        expect_idle_word();
    endtask

    // loopback and pre-emphasis pins go straight through to the device
    task automatic verify_pin_passthrough();
        logic [1:0] pins;
        int         k;
        for (k = 0; k < 4; k++) begin
            pins           = 2'(k);
            i_loopback_ena = pins[1];
            i_tx_pre       = pins[0];
            @(negedge clk);
            check_level(o_2711_loopen, pins[1], "o_2711_loopen");
            check_level(o_2711_pre, pins[0], "o_2711_pre");
        end
        i_loopback_ena = 1'b0;
        i_tx_pre       = 1'b0;
    endtask

    task automatic start_transfer(input logic [2:0] mode, input int body, input int tail,
                                  input int cnt);
        i_tx_mode        = mode;
        i_tx_packet_body = 16'(body);
        i_tx_packet_tail = 16'(tail);
        i_tx_body_num    = 24'(cnt);
        i_tx_start       = 1'b1;
        @(negedge clk);
        i_tx_start = 1'b0;
    endtask

    // ready only moves at the rising edge and holds until the next one
    task automatic feed_dma(input bit random_valid);
        int   idx;
        logic valid;
        idx = 0;
        while (idx < dma_words.size()) begin
            @(negedge clk);
            valid          = random_valid ? 1'($random(seed)) : 1'b1;
            i_dma_rd_valid = valid;
            i_dma_rd_data  = dma_words[idx];
            if (!o_dma_rd_ready) begin
                saw_ready_low = 1'b1;
            end
            if (valid && o_dma_rd_ready) begin
                idx++;
            end
        end
        @(negedge clk);
        i_dma_rd_valid = 1'b0;
    endtask

    ////////////////////////////////////////
    // link monitor
    ////////////////////////////////////////

    task automatic expect_idle_word();
        check_word(o_2711_txd, COMMA_WORD, "o_2711_txd");
        check_kflags({o_2711_tkmsb, o_2711_tklsb}, 2'b01, "o_2711_tkmsb/tklsb");
    endtask

    task automatic watch_frames(input int body, input int tail, input int cnt);
        word_q_t    frame;
        int         commas;
        int         f;
        int         i;
        logic [1:0] kexp;
        for (f = 0; f <= cnt; f++) begin
            frame  = build_frame(f, body, tail, cnt, lane_stream);
            commas = 0;
            @(negedge clk);
            // commas until the start code raises tkmsb
            while (o_2711_tkmsb !== 1'b1) begin
                expect_idle_word();
                commas++;
                @(negedge clk);
            end
            if (f > 0) begin
                check_level(commas >= GAP_CYC, 1'b1, "comma gap between frames");
            end
            for (i = 0; i < frame.size(); i++) begin
                if (i > 0) begin
                    @(negedge clk);
                end
                kexp = (i == 0 || i == frame.size() - 1) ? 2'b11 : 2'b00;
                check_word(o_2711_txd, frame[i], "o_2711_txd");
                check_kflags({o_2711_tkmsb, o_2711_tklsb}, kexp, "o_2711_tkmsb/tklsb");
                check_level(o_tx_interrupt, 1'b0, "o_tx_interrupt");
            end
        end
    endtask

    task automatic watch_interrupt(input logic [15:0] width);
        int commas;
        int high;
        commas = 0;
        high   = 0;
        @(negedge clk);
        while (o_tx_interrupt !== 1'b1) begin
            expect_idle_word();
            commas++;
            @(negedge clk);
        end
        // the last gap comma shares its cycle with the rising interrupt
        check_word(16'(commas + 1), 16'(GAP_CYC), "gap cycles before o_tx_interrupt");
        while (o_tx_interrupt === 1'b1) begin
            expect_idle_word();
            high++;
            @(negedge clk);
        end
        check_word(16'(high), width, "o_tx_interrupt width");
        repeat (4) begin
            expect_idle_word();
            check_level(o_tx_interrupt, 1'b0, "o_tx_interrupt");
            @(negedge clk);
        end
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        i_soft_reset     = 1'b1;
        i_tx_start       = 1'b0;
        i_tx_mode        = NORM;
        i_loopback_ena   = 1'b0;
        i_tx_pre         = 1'b0;
        i_tx_packet_body = '0;
        i_tx_packet_tail = '0;
        i_tx_body_num    = '0;
        i_tx_intr_width  = 16'(INTR_W);
        i_dma_rd_valid   = 1'b0;
        i_dma_rd_data    = '0;

        apply_reset();
        verify_pin_passthrough();

        // three frames with a short last one
        make_stream(A_WORDS);
        start_transfer(NORM, A_BODY, A_TAIL, A_CNT);
        fork
            feed_dma(1'b0);
            begin
                watch_frames(A_BODY, A_TAIL, A_CNT);
                watch_interrupt(16'(INTR_W));
            end
        join

        // random valid against a small fifo
        apply_reset();
        make_stream(B_WORDS);
        saw_ready_low = 1'b0;
        start_transfer(NORM, B_BODY, B_TAIL, B_CNT);
        fork
            feed_dma(1'b1);
            begin
                watch_frames(B_BODY, B_TAIL, B_CNT);
                watch_interrupt(16'(INTR_W));
            end
        join
        check_level(saw_ready_low, 1'b1, "o_dma_rd_ready low while full");

        // continuous start code
        apply_reset();
        start_transfer(KCODE, 0, 0, 0);
        check_word({6'h00, o_tx_status}, {6'h00, 1'b1, 1'b0, IDLE, 1'b0, KCODE},
                   "o_tx_status");
        repeat (KCODE_CYC) begin
            @(negedge clk);
            check_word(o_2711_txd, SOF_WORD, "o_2711_txd");
            check_kflags({o_2711_tkmsb, o_2711_tklsb}, 2'b11, "o_2711_tkmsb/tklsb");
            check_level(o_tx_interrupt, 1'b0, "o_tx_interrupt");
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tlk2711_tx.f
logic/tlk2711_link_pkg.sv
logic/tx_frame_pkg.sv
logic/tx_dma_fifo.sv
logic/tx_frame_ctrl.sv
logic/tx_word_builder.sv
logic/tlk2711_tx.sv
verification/tb_tlk2711_tx.sv

// File: Bender.yml
package:
  name: tlk2711_tx

sources:
  - logic/tlk2711_link_pkg.sv
  - logic/tx_frame_pkg.sv
  - logic/tx_dma_fifo.sv
  - logic/tx_frame_ctrl.sv
  - logic/tx_word_builder.sv
  - logic/tlk2711_tx.sv
  - target: test
    files:
      - verification/tb_tlk2711_tx.sv
